//--- design/flash_boot_pkg.sv
`default_nettype none

package flash_boot_pkg;

	//////////////////////////////////////////////////
	// Flash and memory geometry
	//////////////////////////////////////////////////
	localparam int flash_addr_w = 25;
	localparam int seg_len_w = 24;
	localparam int ram_addr_w = 18;

	//////////////////////////////////////////////////
	// Image layout
	//////////////////////////////////////////////////
	localparam logic [flash_addr_w-1:0] hdr_addr = 25'h400;
	localparam logic [seg_len_w-1:0] hdr_len = 24'd28;
	localparam int crc_bytes = 4;
	localparam int num_segs = 3;

	// One header entry is 8 bytes, address field at byte 4
	localparam int entry_w = 64;
	localparam int entry_addr_ofs = 32;
	localparam int hdr_tab_w = num_segs * entry_w;

	// Reflected CRC-32
	localparam logic [31:0] crc_poly = 32'hEDB88320;
	localparam logic [31:0] crc_residue = 32'hDEBB20E3;

	typedef enum logic [1:0]
	{
		idle,
		read_hdr,
		read_seg,
		wait_check
	} load_state_t;

endpackage

`default_nettype wire

//--- design/crc32_byte_check.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_byte_check
	import flash_boot_pkg::*;
(
	input  wire       sys_clk,
	input  wire       glbl_rst_n,
	input  wire       blk_start,
	input  wire       byte_valid,
	input  wire [7:0] byte_data,
	input  wire       byte_last,
	output logic      crc_pass,
	output logic      crc_fail
);

	logic [31:0] crc_reg;
	logic [31:0] crc_nxt;

	// Eight LSB-first shift steps for one byte
	function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++)
		begin
			if (c[0] ^ d[i])
				c = (c >> 1) ^ crc_poly;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	assign crc_nxt = crc_step(crc_reg, byte_data);

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			crc_reg <= '1;
			crc_pass <= 1'b0;
			crc_fail <= 1'b0;
		end
		else
		begin
			crc_pass <= 1'b0;
			crc_fail <= 1'b0;
			if (blk_start)
				crc_reg <= '1;
			else if (byte_valid)
				crc_reg <= crc_nxt;
			// Trailing CRC folded in leaves only the residue
			if (byte_valid && byte_last)
			begin
				crc_pass <= (crc_nxt == crc_residue);
				crc_fail <= (crc_nxt != crc_residue);
			end
		end
	end

	// A byte in the preset cycle would be lost
	a_no_byte_at_start: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		blk_start |-> !byte_valid);

endmodule

`default_nettype wire

//--- design/flash_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module flash_read_engine
	import flash_boot_pkg::*;
(
	input  wire                    sys_clk,
	input  wire                    glbl_rst_n,
	input  wire                    rd_start,
	input  wire [flash_addr_w-1:0] rd_addr,
	input  wire [seg_len_w-1:0]    rd_len,
	output logic                   busy,
	output logic                   flash_rd_en,
	output logic [flash_addr_w-1:0] flash_rd_addr,
	input  wire [7:0]              flash_rd_data,
	output logic                   byte_valid,
	output logic [7:0]             byte_data,
	output logic                   byte_last
);

	logic [seg_len_w-1:0] remain;
	logic                 rd_final;

	// Last flash read of the command
	assign rd_final = flash_rd_en && (remain == seg_len_w'(1));

	// Busy covers the read phase plus the data returning a cycle later
	assign busy = flash_rd_en | byte_valid;

	//////////////////////////////////////////////////
	// Read issue
	//////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			flash_rd_en <= 1'b0;
			remain <= '0;
		end
		else if (rd_start && !busy)
		begin
			flash_rd_en <= 1'b1;
			remain <= rd_len;
		end
		else if (flash_rd_en)
		begin
			remain <= remain - 1'b1;
			if (rd_final)
				flash_rd_en <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (rd_start && !busy)
			flash_rd_addr <= rd_addr;
		else if (flash_rd_en)
			flash_rd_addr <= flash_rd_addr + 1'b1;
	end

	//////////////////////////////////////////////////
	// Align strobes with the returned byte
	//////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			byte_valid <= 1'b0;
			byte_last <= 1'b0;
		end
		else
		begin
			byte_valid <= flash_rd_en;
			byte_last <= rd_final;
		end
	end

	assign byte_data = flash_rd_data;

	a_cmd_legal: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		rd_start |-> (!busy && rd_len != '0));

endmodule

`default_nettype wire

//--- design/flash_load_xfer.sv
`timescale 1ns/1ps
`default_nettype none

module flash_load_xfer
	import flash_boot_pkg::*;
(
	input  wire                     sys_clk,
	input  wire                     glbl_rst_n,
	input  wire                     load_start,
	output logic                    load_done,
	output logic                    load_error,
	output logic                    load_busy,
	output logic                    rd_start,
	output logic [flash_addr_w-1:0] rd_addr,
	output logic [seg_len_w-1:0]    rd_len,
	input  wire                     byte_valid,
	input  wire [7:0]               byte_data,
	input  wire                     byte_last,
	input  wire                     crc_pass,
	input  wire                     crc_fail,
	output logic                    ram_wr_en,
	output logic [ram_addr_w-1:0]   ram_wr_addr
);

	load_state_t state;

	logic [1:0]              seg_idx;
	logic [seg_len_w-1:0]    byte_idx;
	logic [seg_len_w-1:0]    cur_len;
	logic [hdr_tab_w-1:0]    hdr_tab;
	logic [seg_len_w-1:0]    ent_len;
	logic [flash_addr_w-1:0] ent_addr;
	logic                    all_segs_done;

	// Entry fields of the segment to be read next
	assign ent_len = hdr_tab[seg_idx * entry_w +: seg_len_w];
	assign ent_addr = hdr_tab[seg_idx * entry_w + entry_addr_ofs +: flash_addr_w];
	assign all_segs_done = (seg_idx == 2'(num_segs));

	assign load_busy = (state != idle);

	// Only payload bytes reach the memory
	assign ram_wr_en = (state == read_seg) && byte_valid &&
		(byte_idx + seg_len_w'(crc_bytes) < cur_len);

	//////////////////////////////////////////////////
	// Header table with byte 0 at the bottom
	//////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (state == read_hdr && byte_valid && byte_idx < seg_len_w'(hdr_tab_w / 8))
			hdr_tab <= {byte_data, hdr_tab[hdr_tab_w-1:8]};
	end

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state <= idle;
			rd_start <= 1'b0;
			rd_addr <= '0;
			rd_len <= '0;
			load_done <= 1'b0;
			load_error <= 1'b0;
			seg_idx <= '0;
			byte_idx <= '0;
			cur_len <= '0;
			ram_wr_addr <= '0;
		end
		else
		begin
			rd_start <= 1'b0;
			load_done <= 1'b0;
			load_error <= 1'b0;
			if (byte_valid)
				byte_idx <= byte_idx + 1'b1;
			if (ram_wr_en)
				ram_wr_addr <= ram_wr_addr + 1'b1;
			case (state)
				idle:
				begin
					if (load_start)
					begin
						rd_start <= 1'b1;
						rd_addr <= hdr_addr;
						rd_len <= hdr_len;
						cur_len <= hdr_len;
						byte_idx <= '0;
						seg_idx <= '0;
						ram_wr_addr <= '0;
						state <= read_hdr;
					end
				end
				read_hdr, read_seg:
				begin
					if (byte_valid && byte_last)
						state <= wait_check;
				end
				wait_check:
				begin
					if (crc_fail)
					begin
						load_error <= 1'b1;
						state <= idle;
					end
					else if (crc_pass)
					begin
						if (all_segs_done)
						begin
							load_done <= 1'b1;
							state <= idle;
						end
						else
						begin
							rd_start <= 1'b1;
							rd_addr <= ent_addr;
							rd_len <= ent_len;
							cur_len <= ent_len;
							byte_idx <= '0;
							seg_idx <= seg_idx + 1'b1;
							state <= read_seg;
						end
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	// A check result outside wait_check would leave the FSM stuck
	a_result_in_wait: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		(crc_pass || crc_fail) |-> (state == wait_check));

endmodule

`default_nettype wire

//--- design/init_image_ram.sv
`timescale 1ns/1ps
`default_nettype none

module init_image_ram
	import flash_boot_pkg::*;
(
	input  wire                  sys_clk,
	input  wire                  wr_en,
	input  wire [ram_addr_w-1:0] wr_addr,
	input  wire [7:0]            wr_data,
	input  wire [ram_addr_w-1:0] rd_addr,
	output logic [7:0]           rd_data
);

	logic [7:0] mem [2**ram_addr_w];

	// Loader side
	always_ff @(posedge sys_clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Consumer side, one cycle latency
	always_ff @(posedge sys_clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- design/flash_boot_top.sv
`timescale 1ns/1ps
`default_nettype none

module flash_boot_top
	import flash_boot_pkg::*;
(
	input  wire                     sys_clk,
	input  wire                     glbl_rst_n,
	input  wire                     load_start,
	output logic                    load_done,
	output logic                    load_error,
	output logic                    load_busy,
	output logic                    flash_rd_en,
	output logic [flash_addr_w-1:0] flash_rd_addr,
	input  wire [7:0]               flash_rd_data,
	input  wire [ram_addr_w-1:0]    ram_rd_addr,
	output logic [7:0]              ram_rd_data
);

	logic                    rd_start;
	logic [flash_addr_w-1:0] rd_addr;
	logic [seg_len_w-1:0]    rd_len;
	logic                    byte_valid;
	logic [7:0]              byte_data;
	logic                    byte_last;
	logic                    crc_pass;
	logic                    crc_fail;
	logic                    ram_wr_en;
	logic [ram_addr_w-1:0]   ram_wr_addr;

	flash_read_engine engine_i (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.rd_start      (rd_start),
		.rd_addr       (rd_addr),
		.rd_len        (rd_len),
		.busy          (),
		.flash_rd_en   (flash_rd_en),
		.flash_rd_addr (flash_rd_addr),
		.flash_rd_data (flash_rd_data),
		.byte_valid    (byte_valid),
		.byte_data     (byte_data),
		.byte_last     (byte_last)
	);

	// Checker restarts with every read command
	crc32_byte_check crc_i (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.blk_start  (rd_start),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_last  (byte_last),
		.crc_pass   (crc_pass),
		.crc_fail   (crc_fail)
	);

	flash_load_xfer xfer_i (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.load_start  (load_start),
		.load_done   (load_done),
		.load_error  (load_error),
		.load_busy   (load_busy),
		.rd_start    (rd_start),
		.rd_addr     (rd_addr),
		.rd_len      (rd_len),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.byte_last   (byte_last),
		.crc_pass    (crc_pass),
		.crc_fail    (crc_fail),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_addr (ram_wr_addr)
	);

	init_image_ram ram_i (
		.sys_clk (sys_clk),
		.wr_en   (ram_wr_en),
		.wr_addr (ram_wr_addr),
		.wr_data (byte_data),
		.rd_addr (ram_rd_addr),
		.rd_data (ram_rd_data)
	);

endmodule

`default_nettype wire

//--- sim/flash_image_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_image_model
(
	input  wire        sys_clk,
	input  wire        rd_en,
	input  wire [11:0] rd_addr,
	output logic [7:0] rd_data,
	input  wire        ld_en,
	input  wire [11:0] ld_addr,
	input  wire [7:0]  ld_data
);

	logic [7:0] mem [4096];

	// Erased contents, folded from every address bit
	initial
	begin
		for (int i = 0; i < 4096; i++)
			mem[i] = 8'(i) ^ 8'(i >> 4) ^ 8'(i >> 8) ^ 8'h3C;
	end

	always_ff @(posedge sys_clk)
	begin
		if (ld_en)
			mem[ld_addr] <= ld_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- sim/flash_boot_tb.sv
`timescale 1ns/1ps
`default_nettype none

module flash_boot_tb
	import flash_boot_pkg::*;
();

	localparam int drive_dly = 10;
	localparam int seg_base [num_segs] = '{'h800, 'h900, 'hA00};
	localparam int seg_len [num_segs] = '{20, 9, 36};
	localparam int hdr_base = int'(hdr_addr);
	localparam int img_bytes = int'(hdr_len) + seg_len[0] + seg_len[1] + seg_len[2];
	localparam int payload_bytes = img_bytes - int'(hdr_len) - num_segs * crc_bytes;
	localparam int num_images = 5;
	localparam int end_limit = img_bytes * 2 + 50;
	localparam int watchdog_cycles = num_images * img_bytes * 4 + 400;
	localparam int end_none = 0;
	localparam int end_done = 1;
	localparam int end_error = 2;
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	logic                    sys_clk;
	logic                    glbl_rst_n;
	logic                    load_start;
	logic                    load_done;
	logic                    load_error;
	logic                    load_busy;
	logic                    flash_rd_en;
	logic [flash_addr_w-1:0] flash_rd_addr;
	logic [7:0]              flash_rd_data;
	logic [ram_addr_w-1:0]   ram_rd_addr;
	logic [7:0]              ram_rd_data;
	logic                    ld_en;
	logic [11:0]             ld_addr;
	logic [7:0]              ld_data;

	logic [7:0]  img [4096];
	logic [7:0]  exp_mem [64];
	logic [31:0] lfsr_state;
	int          exp_kind;
	int          done_pulses;
	int          err_pulses;
	int          done_base;
	int          err_base;
	int          chk_err;
	int          proc_err;
	int          errs_seen;
	int          tests_run;

	// Compare strobe and readback pipeline seen by the assertions
	logic        cmp_en;
	string       cmp_name;
	int          cmp_got;
	int          cmp_exp;
	logic        rd_req;
	logic [7:0]  rd_exp;
	logic        rd_chk;
	logic [7:0]  rd_exp_q;
	logic [ram_addr_w-1:0] rd_addr_q;

	flash_boot_top dut_i (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.load_start    (load_start),
		.load_done     (load_done),
		.load_error    (load_error),
		.load_busy     (load_busy),
		.flash_rd_en   (flash_rd_en),
		.flash_rd_addr (flash_rd_addr),
		.flash_rd_data (flash_rd_data),
		.ram_rd_addr   (ram_rd_addr),
		.ram_rd_data   (ram_rd_data)
	);

	flash_image_model flash_i (
		.sys_clk (sys_clk),
		.rd_en   (flash_rd_en),
		.rd_addr (flash_rd_addr[11:0]),
		.rd_data (flash_rd_data),
		.ld_en   (ld_en),
		.ld_addr (ld_addr),
		.ld_data (ld_data)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			done_pulses <= 0;
			err_pulses <= 0;
		end
		else
		begin
			if (load_done)
				done_pulses <= done_pulses + 1;
			if (load_error)
				err_pulses <= err_pulses + 1;
		end
		rd_chk <= rd_req;
		rd_exp_q <= rd_exp;
		rd_addr_q <= ram_rd_addr;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	a_value: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		cmp_en |-> (cmp_got == cmp_exp))
		else
		begin
			chk_err++;
			$display("CHECK FAILED at %0t: %s exp %0d got %0d", $time, cmp_name, cmp_exp,
				cmp_got);
		end

	a_done_expected: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		load_done |-> (exp_kind == end_done))
		else
		begin
			chk_err++;
			$display("CHECK FAILED at %0t: load_done exp 0 got 1", $time);
		end

	a_error_expected: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		load_error |-> (exp_kind == end_error))
		else
		begin
			chk_err++;
			$display("CHECK FAILED at %0t: load_error exp 0 got 1", $time);
		end

	a_ram_readback: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		rd_chk |-> (ram_rd_data == rd_exp_q))
		else
		begin
			chk_err++;
			$display("CHECK FAILED at %0t: ram_rd_data[%0d] exp %02h got %02h", $time,
				$sampled(rd_addr_q), $sampled(rd_exp_q), $sampled(ram_rd_data));
		end

	//////////////////////////////////////////////////
	// Image builder
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ lfsr_taps;
		return s >> 1;
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Standard CRC-32, ones preset and inverted result
	function automatic logic [31:0] crc32_of(input int base, input int n);
		logic [31:0] c;
		c = 32'hFFFFFFFF;
		for (int i = 0; i < n; i++)
		begin
			c = c ^ {24'h0, img[base + i]};
			for (int k = 0; k < 8; k++)
				c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
		end
		return ~c;
	endfunction

	task automatic append_crc(input int base, input int n);
		logic [31:0] c;
		c = crc32_of(base, n);
		for (int j = 0; j < crc_bytes; j++)
			img[base + n + j] = c[8*j +: 8];
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#drive_dly;
	endtask

	task automatic write_flash(input int base, input int n);
		for (int i = 0; i < n; i++)
		begin
			ld_en = 1'b1;
			ld_addr = 12'(base + i);
			ld_data = img[base + i];
			next_cycle();
		end
		ld_en = 1'b0;
	endtask

	// bad_blk 0 is the header, 1 to 3 the segments, -1 a clean image
	task automatic build_image(input int bad_blk, input int bad_idx);
		logic [7:0] b;
		int         e;
		for (int s = 0; s < num_segs; s++)
		begin
			for (int i = 0; i < seg_len[s] - crc_bytes; i++)
			begin
				rand_byte(b);
				img[seg_base[s] + i] = b;
			end
			append_crc(seg_base[s], seg_len[s] - crc_bytes);
		end
		for (int s = 0; s < num_segs; s++)
		begin
			e = hdr_base + 8 * s;
			for (int j = 0; j < 3; j++)
				img[e + j] = 8'(seg_len[s] >> (8 * j));
			img[e + 3] = 8'h00;
			for (int j = 0; j < 4; j++)
				img[e + 4 + j] = 8'(seg_base[s] >> (8 * j));
		end
		append_crc(hdr_base, 8 * num_segs);
		if (bad_blk == 0)
			img[hdr_base + bad_idx] = img[hdr_base + bad_idx] ^ 8'hFF;
		else if (bad_blk > 0)
			img[seg_base[bad_blk-1] + bad_idx] = img[seg_base[bad_blk-1] + bad_idx] ^ 8'hFF;
		write_flash(hdr_base, int'(hdr_len));
		for (int s = 0; s < num_segs; s++)
			write_flash(seg_base[s], seg_len[s]);
	endtask

	// Payload of segments 0 to last_seg lands at consecutive addresses
	task automatic update_shadow(input int last_seg);
		int w;
		w = 0;
		for (int s = 0; s <= last_seg; s++)
		begin
			for (int i = 0; i < seg_len[s] - crc_bytes; i++)
			begin
				exp_mem[w] = img[seg_base[s] + i];
				w++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus and reporting
	//////////////////////////////////////////////////
	task automatic check_value(input string name, input int got, input int exp);
		cmp_name = name;
		cmp_got = got;
		cmp_exp = exp;
		cmp_en = 1'b1;
		next_cycle();
		cmp_en = 1'b0;
	endtask

	task automatic pulse_start();
		load_start = 1'b1;
		next_cycle();
		load_start = 1'b0;
	endtask

	task automatic wait_end(input int limit);
		int n;
		n = 0;
		while (done_pulses + err_pulses == done_base + err_base && n < limit)
		begin
			next_cycle();
			n++;
		end
		if (done_pulses + err_pulses == done_base + err_base)
		begin
			proc_err++;
			$display("no load_done or load_error within %0d cycles at %0t", limit, $time);
		end
	endtask

	task automatic check_end(input int kind);
		check_value("load_done count", done_pulses - done_base, int'(kind == end_done));
		check_value("load_error count", err_pulses - err_base, int'(kind == end_error));
		check_value("load_busy", int'(load_busy), 0);
		exp_kind = end_none;
	endtask

	task automatic run_load(input int kind, input int last_seg);
		exp_kind = kind;
		done_base = done_pulses;
		err_base = err_pulses;
		pulse_start();
		wait_end(end_limit);
		repeat (4) next_cycle();
		check_end(kind);
		update_shadow(last_seg);
	endtask

	task automatic readback(input int first, input int last);
		for (int a = first; a <= last; a++)
		begin
			ram_rd_addr = ram_addr_w'(a);
			rd_exp = exp_mem[a];
			rd_req = 1'b1;
			next_cycle();
		end
		rd_req = 1'b0;
		repeat (2) next_cycle();
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = chk_err + proc_err;
		tests_run++;
		if (errs == errs_seen)
			$display("test %0d %s: ok", tests_run, name);
		else
			$display("test %0d %s: %0d errors", tests_run, name, errs - errs_seen);
		errs_seen = errs;
	endtask

	initial
	begin
		glbl_rst_n = 1'b0;
		load_start = 1'b0;
		ram_rd_addr = '0;
		ld_en = 1'b0;
		ld_addr = '0;
		ld_data = '0;
		cmp_en = 1'b0;
		cmp_name = "";
		cmp_got = 0;
		cmp_exp = 0;
		rd_req = 1'b0;
		rd_exp = '0;
		exp_kind = end_none;
		lfsr_state = 32'd99295;
		chk_err = 0;
		proc_err = 0;
		errs_seen = 0;
		tests_run = 0;
		done_base = 0;
		err_base = 0;
		for (int i = 0; i < 64; i++)
			exp_mem[i] = 8'h00;
		repeat (10) @(posedge sys_clk);
		#drive_dly;
		glbl_rst_n = 1'b1;
		next_cycle();

		build_image(-1, 0);
		run_load(end_done, num_segs - 1);
		finish_test("good image load");

		readback(0, payload_bytes - 1);
		finish_test("payload readback");

		build_image(0, 5);
		run_load(end_error, -1);
		readback(0, payload_bytes - 1);
		finish_test("header corruption");

		// Byte 3 of segment two is still payload
		build_image(2, 3);
		run_load(end_error, 1);
		readback(0, payload_bytes - 1);
		finish_test("segment two corruption");

		build_image(-1, 0);
		run_load(end_done, num_segs - 1);
		readback(0, payload_bytes - 1);
		finish_test("reload after error");

		// Second start lands in the header read
		build_image(-1, 0);
		exp_kind = end_done;
		done_base = done_pulses;
		err_base = err_pulses;
		pulse_start();
		repeat (5) next_cycle();
		check_value("load_busy", int'(load_busy), 1);
		pulse_start();
		wait_end(end_limit);
		repeat (img_bytes * 2) next_cycle();
		check_end(end_done);
		update_shadow(num_segs - 1);
		readback(0, payload_bytes - 1);
		finish_test("start while busy");

		$display("%0d tests run, %0d checks failed", tests_run, chk_err + proc_err);
		if (chk_err + proc_err == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
design/flash_boot_pkg.sv
design/crc32_byte_check.sv
design/flash_read_engine.sv
design/flash_load_xfer.sv
design/init_image_ram.sv
design/flash_boot_top.sv
sim/flash_image_model.sv
sim/flash_boot_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module flash_boot_tb -f sources.f -o flash_boot_sim

./obj_dir/flash_boot_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
